// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_ISA_WIDTH      32   // data and instruction word
`define CPU_REG_ADDR_WIDTH 5    // register index
`define CPU_REG_CNT        32   // general registers, r0 reads as zero
`define CPU_DMEM_DEPTH     64   // data memory words
`define CPU_SWITCH_CNT     16   // toggle switches on the board

`endif

// ==== cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_ISA_WIDTH-1:0]      word_t;        // data or instruction word
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_idx_t;     // general register index
    typedef logic [`CPU_SWITCH_CNT-1:0]     switch_map_t;  // raw switch levels

    // instruction opcode, bits 31 to 26
    typedef enum logic [5:0] {
        NOP  = 6'h00,
        ADD  = 6'h01,   // rd = rs + rt
        SUB  = 6'h02,   // rd = rs - rt
        AND  = 6'h03,
        OR   = 6'h04,
        ADDI = 6'h05,   // rd = rs + imm
        LW   = 6'h06,   // rd = mem[rs + imm]
        SW   = 6'h07,   // mem[rs + imm] = rd
        IN   = 6'h08    // rd = keypad or switches
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_SUB = 2'b01,
        ALU_AND = 2'b10,
        ALU_OR  = 2'b11
    } alu_op_e;

    // bit 1 set means the ex and mem stages are frozen; 2'b01 is unused
    typedef enum logic [1:0] {
        HAZD_NORMAL = 2'b00,   // wb takes the mem stage
        HAZD_RETRY  = 2'b10,   // wb holds its contents
        HAZD_NO_OP  = 2'b11    // wb gets a bubble
    } hazd_ctl_e;

endpackage

// ==== decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,            // strobe from the instruction source
    input  word_t    instr,
    input  logic     stall,                  // hold id/ex and ignore instr
    input  logic     decode_bubble,          // push a no-op into id/ex
    input  word_t    rs_data,                // register file read data
    input  word_t    rt_data,
    output reg_idx_t rs_idx,                 // register file read indices
    output reg_idx_t rt_idx,
    output logic     ex_no_op,
    output logic     ex_reg_write_enable,
    output logic     ex_mem_read_enable,     // LW, and IN for the load-use check
    output logic     ex_mem_write_enable,
    output logic     ex_input_op,
    output logic     ex_use_imm,
    output alu_op_e  ex_alu_op,
    output reg_idx_t ex_rs_idx,
    output reg_idx_t ex_rt_idx,
    output reg_idx_t ex_dest_reg_idx,
    output word_t    ex_rs_data,
    output word_t    ex_rt_data,
    output word_t    ex_imm
);

    opcode_e op;
    logic    reg_write, mem_read, mem_write, input_op, use_imm;
    alu_op_e alu_op;

    assign op     = opcode_e'(instr[31:26]);
    assign rs_idx = instr[20:16];
    assign rt_idx = (op == SW) ? instr[25:21] : instr[15:11];  // store data sits in the rd field

    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        input_op  = 1'b0;
        use_imm   = 1'b0;
        alu_op    = ALU_ADD;                                   // address adder for LW and SW
        case (op)
            ADD:     reg_write = 1'b1;
            SUB:     begin reg_write = 1'b1; alu_op = ALU_SUB; end
            AND:     begin reg_write = 1'b1; alu_op = ALU_AND; end
            OR:      begin reg_write = 1'b1; alu_op = ALU_OR;  end
            ADDI:    begin reg_write = 1'b1; use_imm = 1'b1;   end
            LW:      begin reg_write = 1'b1; mem_read = 1'b1; use_imm = 1'b1; end
            SW:      begin mem_write = 1'b1; use_imm = 1'b1;   end
            IN:      begin reg_write = 1'b1; mem_read = 1'b1; input_op = 1'b1; end
            default: ;                                         // NOP
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_no_op            <= 1'b1;
            ex_reg_write_enable <= 1'b0;
            ex_mem_read_enable  <= 1'b0;
            ex_mem_write_enable <= 1'b0;
            ex_input_op         <= 1'b0;
        end else begin
            if (decode_bubble)
                ex_no_op <= 1'b1;                              // bubble wins over hold
            else if (!stall)
                ex_no_op <= ~instr_valid;
            if (!stall) begin
                ex_reg_write_enable <= reg_write;
                ex_mem_read_enable  <= mem_read;
                ex_mem_write_enable <= mem_write;
                ex_input_op         <= input_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_use_imm      <= use_imm;
            ex_alu_op       <= alu_op;
            ex_rs_idx       <= rs_idx;
            ex_rt_idx       <= rt_idx;
            ex_dest_reg_idx <= instr[25:21];                   // rd is always the target
            ex_rs_data      <= rs_data;
            ex_rt_data      <= rt_data;
            ex_imm          <= word_t'($signed(instr[15:0]));  // sign extended
        end
    end

    a_legal_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        (instr_valid && !stall) |-> instr[31:26] inside {NOP, ADD, SUB, AND, OR, ADDI, LW, SW, IN});

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/10ps

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,                   // ex/mem frozen during input wait
    input  logic     ex_no_op,
    input  logic     ex_reg_write_enable,
    input  logic     ex_mem_read_enable,
    input  logic     ex_mem_write_enable,
    input  logic     ex_input_op,
    input  logic     ex_use_imm,
    input  alu_op_e  ex_alu_op,
    input  reg_idx_t ex_rs_idx,
    input  reg_idx_t ex_rt_idx,
    input  reg_idx_t ex_dest_reg_idx,
    input  word_t    ex_rs_data,
    input  word_t    ex_rt_data,
    input  word_t    ex_imm,
    input  word_t    wb_alu_result,          // from mem/wb
    input  word_t    wb_data,                // write-back value that covers loads too
    input  reg_idx_t wb_dest_reg_idx,
    input  logic     wb_write,
    output logic     mem_no_op,
    output logic     mem_reg_write_enable,
    output logic     mem_mem_read_enable,
    output logic     mem_mem_write_enable,
    output logic     mem_input_op,
    output word_t    mem_alu_result,
    output word_t    mem_store_data,
    output reg_idx_t mem_dest_reg_idx
);

    logic  mem_fwd_ok, fwd_a_mem, fwd_a_wb, fwd_b_mem, fwd_b_wb, held_q;
    word_t opa_fwd, opb_fwd, opa_q, opb_q, opa, opb, alu_b, alu_y;

    // ex/mem forwards only ALU results and loads wait one cycle for mem/wb
    assign mem_fwd_ok = ~mem_no_op & mem_reg_write_enable & ~mem_mem_read_enable
                      & (mem_dest_reg_idx != '0);
    assign fwd_a_mem  = mem_fwd_ok & (mem_dest_reg_idx == ex_rs_idx);
    assign fwd_b_mem  = mem_fwd_ok & (mem_dest_reg_idx == ex_rt_idx);
    assign fwd_a_wb   = wb_write & (wb_dest_reg_idx == ex_rs_idx);
    assign fwd_b_wb   = wb_write & (wb_dest_reg_idx == ex_rt_idx);

    assign opa_fwd = fwd_a_mem ? mem_alu_result : (fwd_a_wb ? wb_data : ex_rs_data);
    assign opb_fwd = fwd_b_mem ? mem_alu_result : (fwd_b_wb ? wb_data : ex_rt_data);

    // a held instruction keeps the operands it saw first while wb drains
    assign opa   = held_q ? opa_q : opa_fwd;
    assign opb   = held_q ? opb_q : opb_fwd;
    assign alu_b = ex_use_imm ? ex_imm : opb;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB: alu_y = opa - alu_b;
            ALU_AND: alu_y = opa & alu_b;
            ALU_OR:  alu_y = opa | alu_b;
            default: alu_y = opa + alu_b;        // wraps at 32 bits
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_q               <= 1'b0;
            mem_no_op            <= 1'b1;
            mem_reg_write_enable <= 1'b0;
            mem_mem_read_enable  <= 1'b0;
            mem_mem_write_enable <= 1'b0;
            mem_input_op         <= 1'b0;
        end else begin
            held_q <= hold;
            if (!hold) begin
                mem_no_op            <= ex_no_op;
                mem_reg_write_enable <= ex_reg_write_enable;
                mem_mem_read_enable  <= ex_mem_read_enable;
                mem_mem_write_enable <= ex_mem_write_enable;
                mem_input_op         <= ex_input_op;
            end
        end
    end

    always_ff @(posedge clk) begin
        opa_q <= opa;
        opb_q <= opb;
        if (!hold) begin
            mem_alu_result   <= alu_y;
            mem_store_data   <= opb;             // forwarded store data
            mem_dest_reg_idx <= ex_dest_reg_idx;
        end
    end

    // an r0 operand is zero whatever ex/mem and mem/wb hold
    a_fwd_rs_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_rs_idx == '0) |-> (opa_fwd == '0));
    a_fwd_rt_not_r0: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_rt_idx == '0) |-> (opb_fwd == '0));
    // a valid ex/mem result that is not held reaches mem/wb on the next edge
    a_mem_to_wb: assert property (@(posedge clk) disable iff (!rst_n)
        (!hold && !mem_no_op) |=> wb_alu_result == $past(mem_alu_result));

endmodule

// ==== data_mem.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module data_mem import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_no_op,                 // from ex/mem
    input  logic  mem_mem_read_enable,
    input  logic  mem_mem_write_enable,
    input  logic  mem_input_op,              // IN, data comes from the user
    input  word_t mem_alu_result,            // word address
    input  word_t mem_store_data,
    output word_t mem_mem_read_data,         // to mem/wb
    output logic  input_enable,              // IN sits in the mem stage
    output logic  gated_no_op                // mem stage seen as no-op by wb
);

    localparam int ADDR_W = $clog2(`CPU_DMEM_DEPTH);

    word_t              mem [`CPU_DMEM_DEPTH];
    logic  [ADDR_W-1:0] addr;

    assign addr              = mem_alu_result[ADDR_W-1:0];   // low bits, wraps over depth
    assign mem_mem_read_data = mem[addr];                    // combinational read
    assign input_enable      = mem_input_op & ~mem_no_op;
    // IN stays a no-op until the hazard unit lets it through with ignore_no_op
    assign gated_no_op       = mem_no_op | mem_input_op;

    always_ff @(posedge clk) begin
        if (mem_mem_write_enable && !mem_no_op)
            mem[addr] <= mem_store_data;
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_no_op |-> !(mem_mem_read_enable && mem_mem_write_enable));

endmodule

// ==== mem_wb_reg.sv ====
`timescale 1ns/10ps

module mem_wb_reg import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  hazd_ctl_e   hazard_control,         // next action for the wb stage
    input  logic        ignore_no_op,           // let a completed IN through
    input  logic        mem_no_op,
    input  logic        mem_reg_write_enable,
    input  logic        mem_mem_read_enable,
    input  logic        input_enable,           // IN in the mem stage
    input  logic        input_complete,         // user has finished the entry
    input  logic        switch_enable,          // take the switches, not the keypad
    input  word_t       mem_alu_result,
    input  word_t       mem_mem_read_data,
    input  word_t       keypad_data,
    input  switch_map_t switch_map,
    input  reg_idx_t    mem_dest_reg_idx,
    output logic        wb_no_op,               // to general_reg
    output logic        wb_reg_write_enable,
    output logic        wb_mem_read_enable,     // selects read data for write back
    output word_t       wb_alu_result,          // also forwarded to execute
    output word_t       wb_mem_read_data,
    output reg_idx_t    wb_dest_reg_idx         // also forwarded to execute
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_no_op            <= 1'b1;
            wb_reg_write_enable <= 1'b0;
            wb_mem_read_enable  <= 1'b0;
        end else begin
            case (hazard_control)
                HAZD_NORMAL: begin
                    wb_no_op            <= mem_no_op & ~ignore_no_op;
                    wb_reg_write_enable <= mem_reg_write_enable;
                    wb_mem_read_enable  <= mem_mem_read_enable;
                end
                HAZD_RETRY: wb_no_op <= wb_no_op;   // whole stage stays put
                default:    wb_no_op <= 1'b1;       // bubble
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hazard_control == HAZD_NORMAL) begin
            wb_alu_result   <= mem_alu_result;
            wb_dest_reg_idx <= mem_dest_reg_idx;
            if (input_enable && input_complete)
                wb_mem_read_data <= switch_enable ? word_t'(switch_map)   // zero extended
                                                  : keypad_data;
            else
                wb_mem_read_data <= mem_mem_read_data;
        end
    end

    a_legal_hazd: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control inside {HAZD_NORMAL, HAZD_NO_OP, HAZD_RETRY});

endmodule

// ==== general_reg.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module general_reg import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wb_no_op,
    input  logic     wb_reg_write_enable,
    input  logic     wb_mem_read_enable,     // memory or input data, not ALU
    input  word_t    wb_alu_result,
    input  word_t    wb_mem_read_data,
    input  reg_idx_t wb_dest_reg_idx,
    input  reg_idx_t rs_idx,                 // read ports from decode
    input  reg_idx_t rt_idx,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    wb_data,                // write port, also a top output
    output logic     wb_write
);

    word_t regs [`CPU_REG_CNT];

    assign wb_data  = wb_mem_read_enable ? wb_mem_read_data : wb_alu_result;
    assign wb_write = wb_reg_write_enable & ~wb_no_op & (wb_dest_reg_idx != '0);

    // reads pass the pending write through, decode latches before the edge
    assign rs_data = (rs_idx == '0) ? '0 :
                     (wb_write && wb_dest_reg_idx == rs_idx) ? wb_data : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 :
                     (wb_write && wb_dest_reg_idx == rt_idx) ? wb_data : regs[rt_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_CNT; i++)
                regs[i] <= '0;
        end else if (wb_write) begin
            regs[wb_dest_reg_idx] <= wb_data;
        end
    end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      instr_valid,
    input  reg_idx_t  instr_rs_idx,          // decode read indices
    input  reg_idx_t  instr_rt_idx,
    input  reg_idx_t  ex_dest_reg_idx,
    input  logic      ex_mem_read_enable,    // load or IN in execute
    input  logic      ex_no_op,
    input  logic      input_enable,          // IN in the mem stage
    input  logic      input_complete,
    output logic      stall,                 // source holds, id/ex holds
    output logic      decode_bubble,         // no-op into id/ex
    output logic      ignore_no_op,          // completed IN passes to wb
    output hazd_ctl_e mem_hazard_control
);

    logic load_use, pending, retry, overlap_q;

    assign load_use = instr_valid & ex_mem_read_enable & ~ex_no_op & (ex_dest_reg_idx != '0)
                    & ((ex_dest_reg_idx == instr_rs_idx) | (ex_dest_reg_idx == instr_rt_idx));
    assign pending  = input_enable & ~input_complete;
    // an input wait that overlapped a load-use stall spends one retry cycle first
    assign retry    = input_enable & input_complete & overlap_q;

    assign stall         = load_use | input_enable;            // through the complete cycle
    assign decode_bubble = stall & ~pending & ~retry;          // ex/mem moves on, id/ex empties
    assign ignore_no_op  = input_enable & input_complete & ~overlap_q;

    always_comb begin
        if (pending)
            mem_hazard_control = HAZD_NO_OP;
        else if (retry)
            mem_hazard_control = HAZD_RETRY;
        else
            mem_hazard_control = HAZD_NORMAL;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            overlap_q <= 1'b0;
        else if (pending && load_use)
            overlap_q <= 1'b1;
        else if (retry)
            overlap_q <= 1'b0;
    end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,         // instruction strobe
    input  word_t       instr,
    input  word_t       keypad_data,         // input hardware levels
    input  switch_map_t switch_map,
    input  logic        input_complete,
    input  logic        switch_enable,
    output logic        stall,               // source must hold instr
    output logic        wb_write,            // one strobe per register write
    output reg_idx_t    wb_dest_reg_idx,
    output word_t       wb_data
);

    reg_idx_t  rs_idx, rt_idx, ex_rs_idx, ex_rt_idx, ex_dest_reg_idx, mem_dest_reg_idx;
    word_t     rs_data, rt_data, ex_rs_data, ex_rt_data, ex_imm;
    word_t     mem_alu_result, mem_store_data, mem_mem_read_data;
    word_t     wb_alu_result, wb_mem_read_data;
    logic      decode_bubble, ignore_no_op, input_enable, gated_no_op;
    logic      ex_no_op, ex_reg_write_enable, ex_mem_read_enable, ex_mem_write_enable;
    logic      ex_input_op, ex_use_imm;
    logic      mem_no_op, mem_reg_write_enable, mem_mem_read_enable, mem_mem_write_enable;
    logic      mem_input_op, wb_no_op, wb_reg_write_enable, wb_mem_read_enable;
    alu_op_e   ex_alu_op;
    hazd_ctl_e mem_hazard_control;

    decode_stage decode_i (
        .clk, .rst_n, .instr_valid, .instr, .stall, .decode_bubble,
        .rs_data, .rt_data, .rs_idx, .rt_idx,
        .ex_no_op, .ex_reg_write_enable, .ex_mem_read_enable, .ex_mem_write_enable,
        .ex_input_op, .ex_use_imm, .ex_alu_op, .ex_rs_idx, .ex_rt_idx,
        .ex_dest_reg_idx, .ex_rs_data, .ex_rt_data, .ex_imm
    );

    execute_stage execute_i (
        .clk, .rst_n,
        .hold                 (mem_hazard_control[1]),   // frozen under NO_OP and RETRY
        .ex_no_op, .ex_reg_write_enable, .ex_mem_read_enable, .ex_mem_write_enable,
        .ex_input_op, .ex_use_imm, .ex_alu_op, .ex_rs_idx, .ex_rt_idx,
        .ex_dest_reg_idx, .ex_rs_data, .ex_rt_data, .ex_imm,
        .wb_alu_result, .wb_data, .wb_dest_reg_idx, .wb_write,
        .mem_no_op, .mem_reg_write_enable, .mem_mem_read_enable, .mem_mem_write_enable,
        .mem_input_op, .mem_alu_result, .mem_store_data, .mem_dest_reg_idx
    );

    data_mem dmem_i (
        .clk, .rst_n, .mem_no_op, .mem_mem_read_enable, .mem_mem_write_enable,
        .mem_input_op, .mem_alu_result, .mem_store_data,
        .mem_mem_read_data, .input_enable, .gated_no_op
    );

    mem_wb_reg mem_wb_i (
        .clk, .rst_n,
        .hazard_control       (mem_hazard_control),
        .ignore_no_op,
        .mem_no_op            (gated_no_op),             // IN counts as no-op until complete
        .mem_reg_write_enable, .mem_mem_read_enable, .input_enable, .input_complete,
        .switch_enable, .mem_alu_result, .mem_mem_read_data, .keypad_data, .switch_map,
        .mem_dest_reg_idx,
        .wb_no_op, .wb_reg_write_enable, .wb_mem_read_enable, .wb_alu_result,
        .wb_mem_read_data, .wb_dest_reg_idx
    );

    general_reg regs_i (
        .clk, .rst_n, .wb_no_op, .wb_reg_write_enable, .wb_mem_read_enable,
        .wb_alu_result, .wb_mem_read_data, .wb_dest_reg_idx, .rs_idx, .rt_idx,
        .rs_data, .rt_data, .wb_data, .wb_write
    );

    hazard_unit hazard_i (
        .clk, .rst_n, .instr_valid,
        .instr_rs_idx         (rs_idx),
        .instr_rt_idx         (rt_idx),
        .ex_dest_reg_idx, .ex_mem_read_enable, .ex_no_op, .input_enable, .input_complete,
        .stall, .decode_bubble, .ignore_no_op, .mem_hazard_control
    );

endmodule

// ==== tb_cpu_core.sv ====
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tb_cpu_core import cpu_pkg::*; ();

    localparam int RESET_CYCLES     = 8;
    localparam int CYCLES_PER_INSTR = 200;                   // watchdog budget per instruction
    localparam int ADDR_W           = $clog2(`CPU_DMEM_DEPTH);

    logic        clk, rst_n, instr_valid, input_complete, switch_enable;
    word_t       instr, keypad_data, wb_data;
    switch_map_t switch_map;
    logic        stall, wb_write;
    reg_idx_t    wb_dest_reg_idx;

    word_t       ref_regs [`CPU_REG_CNT];                    // reference register file
    word_t       ref_mem [`CPU_DMEM_DEPTH];                  // reference data memory
    reg_idx_t    exp_idx_q [$];                              // predicted writes, in order
    word_t       exp_data_q [$];
    logic [31:0] seed = 32'd56830;
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          issued_cnt = 0;
    logic        saw_stall;                                  // stall seen by the last issue
    string       test_name = "reset";

    cpu_core dut_i (
        .clk, .rst_n, .instr_valid, .instr, .keypad_data, .switch_map,
        .input_complete, .switch_enable, .stall, .wb_write, .wb_dest_reg_idx, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                               // 10 ns period
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;            // lcg step
        return seed;
    endfunction

    function automatic int rand_below(int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;                           // upper bits are the better ones
    endfunction

    function automatic word_t r_type(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        return {op, rd, rs, rt, 11'b0};
    endfunction

    function automatic word_t i_type(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [15:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic compare_word(string what, word_t exp, word_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_reg_idx(string what, reg_idx_t exp, reg_idx_t act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAILED %s %s: expected r%0d, actual r%0d", test_name, what, exp, act);
        end
    endtask

    task automatic compare_bit(string what, logic exp, logic act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic expect_write(reg_idx_t rd, word_t val);
        if (rd != '0) begin                                  // r0 never retires a write
            ref_regs[rd] = val;
            exp_idx_q.push_back(rd);
            exp_data_q.push_back(val);
        end
    endtask

    // reference model, applied in program order at acceptance
    task automatic predict(word_t w);
        opcode_e           op;
        reg_idx_t          rd, rs, rt;
        word_t             a, b, imm, res, sum;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        op   = opcode_e'(w[31:26]);
        rd   = w[25:21];
        rs   = w[20:16];
        rt   = w[15:11];
        imm  = {{16{w[15]}}, w[15:0]};
        a    = ref_regs[rs];
        b    = ref_regs[rt];
        sum  = a + imm;
        addr = sum[ADDR_W-1:0];                              // word address wraps over depth
        wr   = 1'b1;
        res  = '0;
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            ADDI:    res = sum;
            LW:      res = ref_mem[addr];
            SW:      begin ref_mem[addr] = ref_regs[rd]; wr = 1'b0; end
            default: wr = 1'b0;                              // NOP, IN is predicted by its test
        endcase
        if (wr)
            expect_write(rd, res);
    endtask

    // holds the word until an edge with stall low takes it
    task automatic issue_instr(word_t w);
        saw_stall = 1'b0;
        issued_cnt++;
        instr_valid = 1'b1;
        instr       = w;
        @(negedge clk);
        while (stall) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
        predict(w);
    endtask

    task automatic issue_r(opcode_e op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
        issue_instr(r_type(op, rd, rs, rt));
    endtask

    task automatic issue_i(opcode_e op, reg_idx_t rd, reg_idx_t rs, logic [15:0] imm);
        issue_instr(i_type(op, rd, rs, imm));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_idx_q.size() != 0 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (exp_idx_q.size() != 0) begin
            err_cnt++;
            $display("%s: %0d predicted writes never appeared", test_name, exp_idx_q.size());
            exp_idx_q.delete();
            exp_data_q.delete();
        end
        repeat (3) @(posedge clk);                           // let stores retire too
        #1;
    endtask

    // write port monitor, wb_write is stable away from the rising edge
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && wb_write) begin
                if (exp_idx_q.size() == 0) begin
                    err_cnt++;
                    $display("%s: unexpected register write to r%0d", test_name, wb_dest_reg_idx);
                end else begin
                    compare_reg_idx("write index", exp_idx_q.pop_front(), wb_dest_reg_idx);
                    compare_word("write data", exp_data_q.pop_front(), wb_data);
                end
            end
        end
    end

    task automatic test_reset();
        test_name = "test_reset";
        @(negedge clk);
        compare_bit("stall", 1'b0, stall);
        compare_bit("wb_write", 1'b0, wb_write);
        @(posedge clk);
        #1;
        for (int k = 1; k < `CPU_REG_CNT; k++)
            issue_r(OR, reg_idx_t'(k), reg_idx_t'(k), 0);   // each register must read zero
        wait_drain();
    endtask

    task automatic test_alu();
        logic [31:0] r;
        reg_idx_t    ra, rb;
        test_name = "test_alu";
        for (int i = 0; i < 8; i++) begin
            ra = reg_idx_t'(1 + rand_below(9));
            rb = reg_idx_t'(10 + rand_below(10));
            r  = next_rand();
            issue_i(ADDI, ra, 0, r[31:16]);
            r  = next_rand();
            issue_i(ADDI, rb, 0, r[31:16]);
            wait_drain();
            issue_r(ADD, 20, ra, rb);
            issue_r(SUB, 21, ra, rb);                        // negatives wrap at 32 bits
            issue_r(AND, 22, ra, rb);
            issue_r(OR, 23, ra, rb);
            wait_drain();
        end
    endtask

    task automatic test_forwarding();
        logic [31:0] r;
        reg_idx_t    rd, rs, rt;
        test_name = "test_forwarding";
        for (int i = 0; i < 24; i++) begin
            rd = reg_idx_t'(1 + rand_below(6));              // small set, dense dependencies
            rs = reg_idx_t'(rand_below(7));
            rt = reg_idx_t'(rand_below(7));
            r  = next_rand();
            case (rand_below(5))
                0:       issue_r(ADD, rd, rs, rt);
                1:       issue_r(SUB, rd, rs, rt);
                2:       issue_r(AND, rd, rs, rt);
                3:       issue_r(OR, rd, rs, rt);
                default: issue_i(ADDI, rd, rs, r[31:16]);
            endcase
        end
        wait_drain();
    endtask

    task automatic test_load_store();
        logic [31:0] r;
        int          addrs [6];
        test_name = "test_load_store";
        for (int i = 0; i < 6; i++) begin
            addrs[i] = rand_below(`CPU_DMEM_DEPTH);
            r        = next_rand();
            issue_i(ADDI, 10, 0, r[31:16]);
            issue_i(SW, 10, 0, 16'(addrs[i]));               // store data forwarded from ex/mem
            compare_bit("stall without hazard", 1'b0, saw_stall);
            issue_i(LW, 11, 0, 16'(addrs[i]));
            issue_r(ADD, 12, 11, 10);                        // needs the load right away
            compare_bit("stall on load-use", 1'b1, saw_stall);
            wait_drain();
        end
        for (int i = 0; i < 6; i++)
            issue_i(LW, reg_idx_t'(13 + i), 0, 16'(addrs[i]));  // latest store per address
        wait_drain();
    endtask

    task automatic run_input(logic use_switches, reg_idx_t rd);
        word_t value;
        keypad_data    = next_rand();
        switch_map     = switch_map_t'(next_rand());
        switch_enable  = use_switches;
        input_complete = 1'b0;
        issue_i(IN, rd, 0, 16'h0);
        repeat (6) begin                                     // user still typing
            @(negedge clk);
            compare_bit("wb_write during input wait", 1'b0, wb_write);
            @(posedge clk);
            #1;
        end
        @(negedge clk);
        compare_bit("stall during input wait", 1'b1, stall);
        @(posedge clk);
        #1;
        value = use_switches ? {{(`CPU_ISA_WIDTH-`CPU_SWITCH_CNT){1'b0}}, switch_map}
                             : keypad_data;
        expect_write(rd, value);
        input_complete = 1'b1;                               // held until the write retires
        wait_drain();
        input_complete = 1'b0;
        issue_r(ADD, 25, rd, rd);                            // the input value reads back
        wait_drain();
    endtask

    task automatic test_input();
        test_name = "test_input";
        run_input(1'b0, 7);
        run_input(1'b1, 8);
    endtask

    task automatic test_r0();
        test_name = "test_r0";
        issue_i(ADDI, 0, 0, 16'h1234);                       // must not retire
        issue_r(ADD, 0, 1, 2);
        issue_r(ADD, 5, 0, 0);                               // forwarding must skip r0
        issue_r(ADD, 6, 0, 1);
        wait_drain();
    endtask

    initial begin
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        keypad_data    = '0;
        switch_map     = '0;
        input_complete = 1'b0;
        switch_enable  = 1'b0;
        saw_stall      = 1'b0;
        for (int k = 0; k < `CPU_REG_CNT; k++)
            ref_regs[k] = '0;
        for (int k = 0; k < `CPU_DMEM_DEPTH; k++)
            ref_mem[k] = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_forwarding();
        test_load_store();
        test_input();
        test_r0();
        $display("errors: %0d, checks: %0d, instructions: %0d", err_cnt, check_cnt, issued_cnt);
        if (err_cnt == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    // budget grows with every issued instruction
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < RESET_CYCLES + CYCLES_PER_INSTR * (issued_cnt + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout in %s after %0d cycles, %0d instructions issued",
                 test_name, cycles, issued_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
cpu_pkg.sv
decode_stage.sv
execute_stage.sv
data_mem.sv
mem_wb_reg.sv
general_reg.sv
hazard_unit.sv
cpu_core.sv
tb_cpu_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core \
    --Mdir obj_dir -o tb_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, pass message not found in sim.log"
exit 1
